// File: dv/modbus_golden.txt
# name hold crc_flip crc_err req_len req_bytes (request CRC appended by the testbench)
#   resp_len resp_bytes (response CRC checked by the testbench) we_pulses do_wdata do_wmask
wr_reg5      0 00 0   6 01 06 00 05 12 34
  6 01 06 00 05 12 34   0 00000000 00000000
wr_regs10    0 00 0  13 01 10 00 0A 00 03 06 AB CD 00 11 55 AA
  6 01 10 00 0A 00 03   0 00000000 00000000
rd_reg5      0 00 0   6 01 03 00 05 00 01
  5 01 03 02 12 34   0 00000000 00000000
rd_regs10    0 00 0   6 01 03 00 0A 00 03
  9 01 03 06 AB CD 00 11 55 AA   0 00000000 00000000
wr_coil3     0 00 0   6 01 05 00 03 FF 00
  6 01 05 00 03 FF 00   1 00000008 00000008
rd_coils     0 00 0   6 01 01 00 00 00 08
  4 01 01 01 08   0 00000000 00000000
bad_crc      0 01 1   6 01 03 00 05 00 01
  0   0 00000000 00000000
after_bad    0 00 1   6 01 03 00 05 00 01
  5 01 03 02 12 34   0 00000000 00000000
fc02         0 00 1   6 01 02 00 00 00 08
  0   0 00000000 00000000
short        0 00 1   1 01
  0   0 00000000 00000000
after_short  0 00 1   6 01 03 00 0A 00 01
  5 01 03 02 AB CD   0 00000000 00000000
credit_hold  1 00 1   6 01 03 00 0A 00 03
  9 01 03 06 AB CD 00 11 55 AA   0 00000000 00000000

// File: vlog.f
hw/modbus_pkg.sv
hw/crc16_modbus.sv
hw/rtu_receiver.sv
hw/request_executor.sv
hw/tx_framer.sv
hw/modbus_slave_top.sv
dv/modbus_tb.sv

// File: Bender.yml
package:
  name: modbus_rtu_slave

sources:
  - files:
      - hw/modbus_pkg.sv
      - hw/crc16_modbus.sv
      - hw/rtu_receiver.sv
      - hw/request_executor.sv
      - hw/tx_framer.sv
      - hw/modbus_slave_top.sv
  - target: simulation
    files:
      - dv/modbus_tb.sv

// File: dv/modbus_tb.sv
// Testbench for the Modbus RTU slave
// Reads request and response records from the golden file, drives the frames,
// returns transmit credits and checks response bytes, coil writes and status

`timescale 1ns/100ps

module modbus_tb;
  import modbus_pkg::*;

  localparam int MAX_BYTES     = 64;
  localparam int WAIT_CYCLES   = 2000;
  localparam int QUIET_CYCLES  = 300;
  localparam int SETTLE_CYCLES = 40;

  logic  clk;
  logic  rst;
  byte_t rx_b;
  logic  rx_b_v;
  logic  frame_start;
  logic  frame_end;
  byte_t tx_b;
  logic  tx_b_v;
  logic  tx_credit;
  coil_t do_wdata;
  coil_t do_wmask;
  logic  do_we;
  logic  stat_crc_err;

  // Sink state
  byte_t       tx_q[$];
  int          credit_due[$];
  int          cyc;
  logic        hold_credits;
  logic [15:0] lfsr;
  logic [1:0]  delay;
  int          we_cnt;
  coil_t       we_data;
  coil_t       we_mask;

  // Current golden record
  string name;
  int    hold;
  int    flip;
  int    exp_err;
  int    nreq;
  int    nresp;
  byte_t req_b [MAX_BYTES];
  byte_t resp_b [MAX_BYTES];
  int    exp_we;
  coil_t exp_wdata;
  coil_t exp_wmask;

  int   errors;
  int   test_errs;
  int   tests;
  logic aborted;

  modbus_slave_top DUT (
    .clk          (clk),
    .rst          (rst),
    .rx_b         (rx_b),
    .rx_b_v       (rx_b_v),
    .frame_start  (frame_start),
    .frame_end    (frame_end),
    .tx_b         (tx_b),
    .tx_b_v       (tx_b_v),
    .tx_credit    (tx_credit),
    .do_wdata     (do_wdata),
    .do_wmask     (do_wmask),
    .do_we        (do_we),
    .stat_crc_err (stat_crc_err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Modbus CRC-16 fed one message bit at a time from the LSB
  function automatic word_t crc_add(input word_t c_in, input byte_t d);
    word_t c;
    logic  fb;
    c = c_in;
    for (int i = 0; i < 8; i++) begin
      fb = c[0] ^ d[i];
      c  = c >> 1;
      if (fb) c = c ^ CRC_POLY;
    end
    return c;
  endfunction

  // ============================================================
  // Sink for transmit bytes, coil writes and credit return
  // ============================================================
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (!rst) begin
      if (tx_b_v) begin
        tx_q.push_back(tx_b);
        // Two LFSR bits give a 0 to 3 cycle credit delay
        for (int k = 0; k < 2; k++) begin
          delay = {delay[0], lfsr[0]};
          lfsr  = lfsr_next(lfsr);
        end
        credit_due.push_back(cyc + delay);
      end
      if (do_we) begin
        we_cnt  = we_cnt + 1;
        we_data = do_wdata;
        we_mask = do_wmask;
      end
      tx_credit = 1'b0;
      if (!hold_credits && credit_due.size() > 0) begin
        if (credit_due[0] <= cyc) begin
          tx_credit = 1'b1;
          void'(credit_due.pop_front());
        end
      end
    end
  end

  task automatic wait_bytes(input int n, output logic ok);
    int t;
    t = 0;
    while (tx_q.size() < n && t < WAIT_CYCLES) begin
      @(negedge clk);
      t++;
    end
    ok = (tx_q.size() >= n);
  endtask

  task automatic wait_credits_back(output logic ok);
    int t;
    t = 0;
    while (credit_due.size() != 0 && t < WAIT_CYCLES) begin
      @(negedge clk);
      t++;
    end
    ok = (credit_due.size() == 0);
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
    end
  endtask

  // Request bytes, then the CRC low and high byte, then the frame_end pulse
  task automatic send_frame();
    word_t crc;
    int    total;
    crc = CRC_INIT;
    for (int i = 0; i < nreq; i++) begin
      crc = crc_add(crc, req_b[i]);
    end
    req_b[nreq]     = crc[7:0];
    req_b[nreq + 1] = crc[15:8] ^ byte_t'(flip);
    total = nreq + 2;
    for (int i = 0; i < total; i++) begin
      @(negedge clk);
      rx_b        = req_b[i];
      rx_b_v      = 1'b1;
      frame_start = (i == 0);
    end
    @(negedge clk);
    rx_b_v      = 1'b0;
    frame_start = 1'b0;
    frame_end   = 1'b1;
    @(negedge clk);
    frame_end = 1'b0;
  endtask

  // ============================================================
  // One golden record
  // ============================================================
  task automatic run_test();
    logic  ok;
    word_t crc;
    int    nexp;
    int    ncmp;
    test_errs = 0;
    wait_credits_back(ok);
    if (!ok) begin
      $display("timeout: transmit credits did not come back before test %s", name);
      test_errs++;
      aborted = 1'b1;
      return;
    end
    tx_q.delete();
    we_cnt       = 0;
    hold_credits = (hold != 0);
    send_frame();
    if (hold != 0) begin
      wait_bytes(TX_CREDITS, ok);
      if (!ok) begin
        $display("timeout: test %s never used up its transmit credits", name);
        test_errs++;
        aborted = 1'b1;
        return;
      end
      idle_cycles(SETTLE_CYCLES);
      if (tx_q.size() > TX_CREDITS) begin
        $display("mismatch at %0t: %s sent %0d bytes with only %0d credits",
                 $time, name, tx_q.size(), TX_CREDITS);
        test_errs++;
      end
      hold_credits = 1'b0;
    end
    if (nresp > 0) begin
      crc = CRC_INIT;
      for (int i = 0; i < nresp; i++) begin
        crc = crc_add(crc, resp_b[i]);
      end
      resp_b[nresp]     = crc[7:0];
      resp_b[nresp + 1] = crc[15:8];
      nexp = nresp + 2;
      wait_bytes(nexp, ok);
      if (!ok) begin
        $display("timeout: test %s waited for %0d response bytes and got %0d",
                 name, nexp, tx_q.size());
        test_errs++;
        aborted = 1'b1;
        return;
      end
      idle_cycles(SETTLE_CYCLES);
    end else begin
      nexp = 0;
      idle_cycles(QUIET_CYCLES);
    end
    if (tx_q.size() != nexp) begin
      $display("mismatch at %0t: %s sent %0d bytes, expected %0d",
               $time, name, tx_q.size(), nexp);
      test_errs++;
    end
    ncmp = (tx_q.size() < nexp) ? tx_q.size() : nexp;
    for (int i = 0; i < ncmp; i++) begin
      if (tx_q[i] != resp_b[i]) begin
        $display("mismatch at %0t: %s byte %0d is %02h, expected %02h",
                 $time, name, i, tx_q[i], resp_b[i]);
        test_errs++;
      end
    end
    if (we_cnt != exp_we) begin
      $display("mismatch at %0t: %s gave %0d do_we pulses, expected %0d",
               $time, name, we_cnt, exp_we);
      test_errs++;
    end else if (exp_we != 0 && (we_data != exp_wdata || we_mask != exp_wmask)) begin
      $display("mismatch at %0t: %s wrote data %08h mask %08h, expected %08h %08h",
               $time, name, we_data, we_mask, exp_wdata, exp_wmask);
      test_errs++;
    end
    if (stat_crc_err !== exp_err[0]) begin
      $display("mismatch at %0t: %s stat_crc_err is %b, expected %0d",
               $time, name, stat_crc_err, exp_err);
      test_errs++;
    end
  endtask

  // Skips comment lines, then reads one record
  task automatic read_record(input int fd, output logic got);
    string tok;
    int    r;
    int    ch;
    got = 1'b0;
    r   = $fscanf(fd, "%s", tok);
    while (r == 1 && tok.len() > 0 && tok[0] == "#") begin
      ch = $fgetc(fd);
      while (ch != "\n" && ch != -1) begin
        ch = $fgetc(fd);
      end
      r = $fscanf(fd, "%s", tok);
    end
    if (r != 1) return;
    name = tok;
    r = $fscanf(fd, "%d %h %d %d", hold, flip, exp_err, nreq);
    for (int i = 0; i < nreq && i < MAX_BYTES - 2; i++) begin
      r = $fscanf(fd, "%h", req_b[i]);
    end
    r = $fscanf(fd, "%d", nresp);
    for (int i = 0; i < nresp && i < MAX_BYTES - 2; i++) begin
      r = $fscanf(fd, "%h", resp_b[i]);
    end
    r   = $fscanf(fd, "%d %h %h", exp_we, exp_wdata, exp_wmask);
    got = (r == 3);
  endtask

  initial begin
    int   fd;
    logic got;
    rst          = 1'b1;
    rx_b         = '0;
    rx_b_v       = 1'b0;
    frame_start  = 1'b0;
    frame_end    = 1'b0;
    tx_credit    = 1'b0;
    hold_credits = 1'b0;
    lfsr         = 16'd16;
    delay        = '0;
    cyc          = 0;
    we_cnt       = 0;
    errors       = 0;
    tests        = 0;
    aborted      = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    fd  = $fopen("dv/modbus_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file dv/modbus_golden.txt");
      errors++;
    end else begin
      read_record(fd, got);
      while (got && !aborted) begin
        run_test();
        tests++;
        errors += test_errs;
        if (test_errs == 0) begin
          $display("test %-12s ok", name);
        end else begin
          $display("test %-12s failed with %0d errors", name, test_errs);
        end
        read_record(fd, got);
      end
      $fclose(fd);
    end
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0 && tests > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: hw/modbus_slave_top.sv
// Modbus RTU slave top level
// Receiver, request executor and transmit framer

`timescale 1ns/100ps

module modbus_slave_top (
  input  logic              clk,
  input  logic              rst,
  input  modbus_pkg::byte_t rx_b,
  input  logic              rx_b_v,
  input  logic              frame_start,
  input  logic              frame_end,
  output modbus_pkg::byte_t tx_b,
  output logic              tx_b_v,
  input  logic              tx_credit,
  output modbus_pkg::coil_t do_wdata,
  output modbus_pkg::coil_t do_wmask,
  output logic              do_we,
  output logic              stat_crc_err
);
  import modbus_pkg::*;

  // Receive buffer hand-over
  logic     frame_ok;
  buf_idx_t frame_len;
  buf_idx_t rd_addr;
  byte_t    rd_data;
  logic     rx_release;

  // Response stream
  byte_t resp_byte;
  logic  resp_valid;
  logic  resp_last;
  logic  resp_ready;

  rtu_receiver u_rx (
    .clk          (clk),
    .rst          (rst),
    .rx_b         (rx_b),
    .rx_b_v       (rx_b_v),
    .frame_start  (frame_start),
    .frame_end    (frame_end),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .frame_ok     (frame_ok),
    .frame_len    (frame_len),
    .rx_release   (rx_release),
    .stat_crc_err (stat_crc_err)
  );

  request_executor u_exec (
    .clk        (clk),
    .rst        (rst),
    .frame_ok   (frame_ok),
    .frame_len  (frame_len),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .rx_release (rx_release),
    .resp_byte  (resp_byte),
    .resp_valid (resp_valid),
    .resp_last  (resp_last),
    .resp_ready (resp_ready),
    .do_wdata   (do_wdata),
    .do_wmask   (do_wmask),
    .do_we      (do_we)
  );

  tx_framer u_tx (
    .clk        (clk),
    .rst        (rst),
    .resp_byte  (resp_byte),
    .resp_valid (resp_valid),
    .resp_last  (resp_last),
    .resp_ready (resp_ready),
    .tx_b       (tx_b),
    .tx_b_v     (tx_b_v),
    .tx_credit  (tx_credit)
  );

endmodule

// File: hw/tx_framer.sv
// Transmit buffer with CRC append
// Credit-controlled byte output toward the line

`timescale 1ns/100ps

module tx_framer (
  input  logic              clk,
  input  logic              rst,
  input  modbus_pkg::byte_t resp_byte,
  input  logic              resp_valid,
  input  logic              resp_last,
  output logic              resp_ready,
  output modbus_pkg::byte_t tx_b,
  output logic              tx_b_v,
  input  logic              tx_credit
);
  import modbus_pkg::*;

  typedef enum logic {S_FILL, S_SEND} state_t;

  state_t          state;
  byte_t           tx_mem [BUF_DEPTH];
  buf_idx_t        fill_ptr;
  logic [BUF_AW:0] data_cnt;
  logic [BUF_AW:0] send_idx;
  credit_t         credits;
  word_t           crc;
  logic            push;
  logic            issue;
  logic            send_done;

  assign resp_ready = (state == S_FILL);
  assign push       = resp_valid && resp_ready;
  // A byte leaves only while a credit is left
  assign issue      = (state == S_SEND) && (credits != '0);
  // Frame ends with the CRC high byte
  assign send_done  = issue && (send_idx == data_cnt + 1'b1);

  crc16_modbus u_crc (
    .clk   (clk),
    .rst   (rst),
    .clr   (send_done),
    .valid (push),
    .data  (resp_byte),
    .crc   (crc)
  );

  // Buffer and output byte
  always_ff @(posedge clk) begin
    if (push) begin
      tx_mem[fill_ptr] <= resp_byte;
    end
    if (issue) begin
      if (send_idx < data_cnt) begin
        tx_b <= tx_mem[send_idx[BUF_AW-1:0]];
      end else if (send_idx == data_cnt) begin
        tx_b <= crc[7:0];
      end else begin
        tx_b <= crc[15:8];
      end
    end
  end

  // ============================================================
  // Fill, send and credit accounting
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_FILL;
      fill_ptr <= '0;
      data_cnt <= '0;
      send_idx <= '0;
      credits  <= credit_t'(TX_CREDITS);
      tx_b_v   <= 1'b0;
    end else begin
      tx_b_v <= issue;
      case ({issue, tx_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;
      endcase
      if (push) begin
        fill_ptr <= fill_ptr + 1'b1;
        if (resp_last) begin
          data_cnt <= {1'b0, fill_ptr} + 1'b1;
          send_idx <= '0;
          state    <= S_SEND;
        end
      end
      if (issue) begin
        send_idx <= send_idx + 1'b1;
        if (send_done) begin
          fill_ptr <= '0;
          state    <= S_FILL;
        end
      end
    end
  end

endmodule

// File: hw/request_executor.sv
// Modbus request decode and execution
// Holding register file, coil image and coil write port
// Response byte stream without CRC

`timescale 1ns/100ps

module request_executor (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 frame_ok,
  input  modbus_pkg::buf_idx_t frame_len,
  output modbus_pkg::buf_idx_t rd_addr,
  input  modbus_pkg::byte_t    rd_data,
  output logic                 rx_release,
  output modbus_pkg::byte_t    resp_byte,
  output logic                 resp_valid,
  output logic                 resp_last,
  input  logic                 resp_ready,
  output modbus_pkg::coil_t    do_wdata,
  output modbus_pkg::coil_t    do_wmask,
  output logic                 do_we
);
  import modbus_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE, S_HDR, S_DECODE, S_WREGS, S_NOTIFY, S_RESP, S_DROP
  } state_t;
  typedef enum logic [1:0] {K_ECHO, K_REGS, K_COILS} kind_t;

  state_t state;
  kind_t  resp_kind;
  word_t  regs [REG_WORDS];
  coil_t  coil_img;
  coil_t  coil_bit;

  // Request header and its fields
  byte_t      hdr [ECHO_LEN];
  logic [2:0] hdr_cnt;
  buf_idx_t   rd_ptr;
  buf_idx_t   req_len;
  byte_t      func_code;
  word_t      start_addr;
  word_t      qty_val;
  logic       len_fixed;
  logic       len_wregs;

  // FC10 word collection
  buf_idx_t          wr_cnt;
  buf_idx_t          wr_bytes;
  logic [REG_AW-1:0] wr_reg;
  byte_t             hi_byte;

  // Response generation
  buf_idx_t               resp_idx;
  buf_idx_t               resp_len;
  buf_idx_t               data_off;
  byte_t                  bcnt;
  logic                   push;
  logic [REG_AW-1:0]      reg_sel;
  word_t                  rd_word;
  logic [COIL_AW-1:0]     coil_shift;
  logic [2*COIL_BITS-1:0] coil_dbl;
  word_t                  coil_left;
  byte_t                  coil_mask;

  assign func_code  = hdr[1];
  assign start_addr = {hdr[2], hdr[3]};
  assign qty_val    = {hdr[4], hdr[5]};
  assign coil_bit   = coil_t'(1) << start_addr[COIL_AW-1:0];
  assign len_fixed  = (req_len == buf_idx_t'(REQ_FIXED_LEN));
  // FC10 length is header, byte count, data words and two CRC bytes
  assign len_wregs  = ({qty_val, 1'b0} + 17'(WR_DATA_OFS + 2)) == 17'(req_len);
  assign rd_addr    = rd_ptr;

  assign resp_valid = (state == S_RESP);
  assign push       = resp_valid && resp_ready;
  assign resp_len   = (resp_kind == K_ECHO) ? buf_idx_t'(ECHO_LEN)
                                            : bcnt + buf_idx_t'(RESP_HDR_LEN);
  assign resp_last  = resp_valid && (resp_idx == resp_len - 1'b1);
  assign rx_release = (push && resp_last) || (state == S_DROP);

  // ============================================================
  // Read data selection
  // ============================================================
  assign data_off   = resp_idx - buf_idx_t'(RESP_HDR_LEN);
  assign reg_sel    = start_addr[REG_AW-1:0] + data_off[REG_AW:1];
  assign rd_word    = regs[reg_sel];
  // Coil byte k starts at coil start + 8k, wrapped around the image
  assign coil_shift = start_addr[COIL_AW-1:0] + COIL_AW'({data_off, 3'b000});
  assign coil_dbl   = {coil_img, coil_img} >> coil_shift;
  assign coil_left  = qty_val - 16'({data_off, 3'b000});
  assign coil_mask  = (coil_left >= 16'd8) ? 8'hFF : (8'd1 << coil_left[2:0]) - 8'd1;

  always_comb begin
    if (resp_kind == K_ECHO || resp_idx < 2) begin
      resp_byte = hdr[resp_idx[2:0]];
    end else if (resp_idx == 2) begin
      resp_byte = bcnt;
    end else if (resp_kind == K_REGS) begin
      // High byte first
      resp_byte = data_off[0] ? rd_word[7:0] : rd_word[15:8];
    end else begin
      resp_byte = coil_dbl[7:0] & coil_mask;
    end
  end

  // ============================================================
  // Request FSM
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_IDLE;
      rd_ptr   <= '0;
      hdr_cnt  <= '0;
      wr_cnt   <= '0;
      resp_idx <= '0;
      coil_img <= '0;
      do_we    <= 1'b0;
      do_wdata <= '0;
      do_wmask <= '0;
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      do_we <= 1'b0;
      case (state)
        S_IDLE: begin
          if (frame_ok) begin
            req_len  <= frame_len;
            rd_ptr   <= '0;
            hdr_cnt  <= '0;
            resp_idx <= '0;
            state    <= S_HDR;
          end
        end
        S_HDR: begin
          // Read data trails the address by one cycle
          rd_ptr  <= rd_ptr + 1'b1;
          hdr_cnt <= hdr_cnt + 1'b1;
          if (hdr_cnt != '0) hdr[hdr_cnt - 3'd1] <= rd_data;
          if (hdr_cnt == 3'(ECHO_LEN)) state <= S_DECODE;
        end
        S_DECODE: begin
          state <= S_DROP;
          case (func_code)
            FC_READ_COILS: begin
              if (len_fixed && qty_val != '0 && qty_val <= MAX_RD_COILS) begin
                resp_kind <= K_COILS;
                bcnt      <= byte_t'((qty_val + 16'd7) >> 3);
                state     <= S_RESP;
              end
            end
            FC_READ_HOLDING: begin
              if (len_fixed && qty_val != '0 && qty_val <= MAX_RD_REGS) begin
                resp_kind <= K_REGS;
                bcnt      <= byte_t'({qty_val, 1'b0});
                state     <= S_RESP;
              end
            end
            FC_WRITE_COIL: begin
              if (len_fixed) begin
                coil_img[start_addr[COIL_AW-1:0]] <= (qty_val == COIL_ON);
                do_wmask  <= coil_bit;
                do_wdata  <= (qty_val == COIL_ON) ? coil_bit : '0;
                do_we     <= 1'b1;
                resp_kind <= K_ECHO;
                state     <= S_NOTIFY;
              end
            end
            FC_WRITE_REG: begin
              if (len_fixed) begin
                regs[start_addr[REG_AW-1:0]] <= qty_val;
                resp_kind <= K_ECHO;
                state     <= S_RESP;
              end
            end
            FC_WRITE_REGS: begin
              if (len_wregs) begin
                rd_ptr    <= buf_idx_t'(WR_DATA_OFS);
                wr_cnt    <= '0;
                wr_bytes  <= buf_idx_t'({qty_val, 1'b0});
                wr_reg    <= start_addr[REG_AW-1:0];
                resp_kind <= K_ECHO;
                state     <= S_WREGS;
              end
            end
            default: ;
          endcase
        end
        S_WREGS: begin
          rd_ptr <= rd_ptr + 1'b1;
          wr_cnt <= wr_cnt + 1'b1;
          if (wr_cnt[0]) begin
            hi_byte <= rd_data;
          end else if (wr_cnt != '0) begin
            regs[wr_reg] <= {hi_byte, rd_data};
            wr_reg       <= wr_reg + 1'b1;
          end
          if (wr_cnt == wr_bytes) state <= S_RESP;
        end
        // do_we is high here, one cycle ahead of the echo
        S_NOTIFY: state <= S_RESP;
        S_RESP: begin
          if (push) begin
            resp_idx <= resp_idx + 1'b1;
            if (resp_last) state <= S_IDLE;
          end
        end
        S_DROP:  state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: hw/rtu_receiver.sv
// RTU frame collector with receive buffer
// Length and CRC residual check, hand-over to the executor

`timescale 1ns/100ps

module rtu_receiver (
  input  logic                 clk,
  input  logic                 rst,
  input  modbus_pkg::byte_t    rx_b,
  input  logic                 rx_b_v,
  input  logic                 frame_start,
  input  logic                 frame_end,
  input  modbus_pkg::buf_idx_t rd_addr,
  output modbus_pkg::byte_t    rd_data,
  output logic                 frame_ok,
  output modbus_pkg::buf_idx_t frame_len,
  input  logic                 rx_release,
  output logic                 stat_crc_err
);
  import modbus_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_COLLECT, S_HOLD} state_t;

  state_t   state;
  byte_t    rx_mem [BUF_DEPTH];
  buf_idx_t rx_len;
  buf_idx_t wr_idx;
  logic     take;
  logic     crc_clr;
  word_t    crc;

  // Bytes are taken only while a frame is open and the buffer is free
  assign take      = rx_b_v && (state != S_HOLD) && (frame_start || state == S_COLLECT);
  assign crc_clr   = frame_start && (state != S_HOLD);
  assign wr_idx    = frame_start ? '0 : rx_len;
  assign frame_len = rx_len;

  crc16_modbus u_crc (
    .clk   (clk),
    .rst   (rst),
    .clr   (crc_clr),
    .valid (take),
    .data  (rx_b),
    .crc   (crc)
  );

  // Buffer write and registered read port
  always_ff @(posedge clk) begin
    if (take) begin
      rx_mem[wr_idx] <= rx_b;
    end
    rd_data <= rx_mem[rd_addr];
  end

  // ============================================================
  // Frame control
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      rx_len       <= '0;
      frame_ok     <= 1'b0;
      stat_crc_err <= 1'b0;
    end else begin
      frame_ok <= 1'b0;
      // Length saturates at the last buffer slot
      if (take) begin
        rx_len <= (wr_idx == '1) ? wr_idx : wr_idx + 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (frame_start) state <= S_COLLECT;
        end
        S_COLLECT: begin
          if (frame_end) begin
            if (rx_len < buf_idx_t'(MIN_FRAME_LEN)) begin
              state <= S_IDLE;
            end else if (crc != '0) begin
              // Residual over data and CRC bytes must be zero
              stat_crc_err <= 1'b1;
              state        <= S_IDLE;
            end else begin
              frame_ok <= 1'b1;
              state    <= S_HOLD;
            end
          end
        end
        S_HOLD: begin
          if (rx_release) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: hw/crc16_modbus.sv
// Byte-serial Modbus CRC-16 accumulator
// Reflected polynomial, all-ones start value, one byte per clock

`timescale 1ns/100ps

module crc16_modbus (
  input  logic              clk,
  input  logic              rst,
  input  logic              clr,
  input  logic              valid,
  input  modbus_pkg::byte_t data,
  output modbus_pkg::word_t crc
);
  import modbus_pkg::*;

  word_t crc_base;

  // Eight shift and XOR steps, LSB first
  function automatic word_t crc_byte(input word_t c_in, input byte_t d);
    word_t c;
    c = c_in ^ {8'h00, d};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  // A byte together with clr starts a fresh CRC
  assign crc_base = clr ? CRC_INIT : crc;

  always_ff @(posedge clk) begin
    if (rst) begin
      crc <= CRC_INIT;
    end else if (valid) begin
      crc <= crc_byte(crc_base, data);
    end else if (clr) begin
      crc <= CRC_INIT;
    end
  end

endmodule

// File: hw/modbus_pkg.sv
// Modbus RTU slave constants and shared types
// Buffer sizes, function codes, request layout and CRC settings

package modbus_pkg;

  // ============================================================
  // Sizes
  // ============================================================
  localparam int REG_WORDS     = 64;
  localparam int REG_AW        = 6;
  localparam int BUF_DEPTH     = 256;
  localparam int BUF_AW        = 8;
  localparam int COIL_BITS     = 32;
  localparam int COIL_AW       = $clog2(COIL_BITS);
  localparam int TX_CREDITS    = 4;
  localparam int MIN_FRAME_LEN = 4;

  typedef logic [7:0]           byte_t;
  typedef logic [15:0]          word_t;
  typedef logic [BUF_AW-1:0]    buf_idx_t;
  typedef logic [COIL_BITS-1:0] coil_t;
  typedef logic [2:0]           credit_t;

  // ============================================================
  // Protocol
  // ============================================================
  localparam word_t CRC_INIT = 16'hFFFF;
  localparam word_t CRC_POLY = 16'hA001;
  localparam word_t COIL_ON  = 16'hFF00;

  localparam byte_t FC_READ_COILS   = 8'h01;
  localparam byte_t FC_READ_HOLDING = 8'h03;
  localparam byte_t FC_WRITE_COIL   = 8'h05;
  localparam byte_t FC_WRITE_REG    = 8'h06;
  localparam byte_t FC_WRITE_REGS   = 8'h10;

  // Request layout is slave, func, start(2) and qty or value(2) ahead of the CRC
  localparam int REQ_FIXED_LEN = 8;
  // Echoed part of a write request
  localparam int ECHO_LEN      = 6;
  // Slave, func and byte count ahead of read data
  localparam int RESP_HDR_LEN  = 3;
  // First data byte of an FC10 request, after the byte count
  localparam int WR_DATA_OFS   = 7;

  // Read quantities that still fit one response frame
  localparam int MAX_RD_REGS  = 125;
  localparam int MAX_RD_COILS = 2000;

endpackage
